/* verilog/dmacRegPkg.sv */
/*
 * SDMAC register map
 * Register indices and the bit positions used in the control and status words
 */

package dmacRegPkg;

    // Register address width, four registers in the map
    localparam int REG_ADDR_W = 2;

    // Register indices
    localparam logic [REG_ADDR_W-1:0] REG_CONTROL = 2'd0;  // DMA and interrupt enables
    localparam logic [REG_ADDR_W-1:0] REG_ADDRESS = 2'd1;  // Live memory address
    localparam logic [REG_ADDR_W-1:0] REG_COUNT   = 2'd2;  // Longwords left to move
    localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 2'd3;  // Done flag and FIFO flags

    // Control word bits
    localparam int CTRL_DMA_ENA = 0;  // Peripheral to memory DMA enabled
    localparam int CTRL_INT_ENA = 1;  // Raise irq when done

    // Status word bits
    // Writing 1 to the done bit clears it
    localparam int STAT_DONE       = 0;
    localparam int STAT_FIFO_EMPTY = 1;
    localparam int STAT_FIFO_FULL  = 2;

endpackage

/* verilog/dmacBusPkg.sv */
/*
 * SDMAC bus definitions
 * Data widths, byte lane count and the payload types shared by the datapath
 */

package dmacBusPkg;

    localparam int LANES   = 4;   // Byte lanes in one longword
    localparam int BYTE_W  = 8;   // Peripheral port and lane width
    localparam int WORD_W  = 32;  // Memory bus longword
    localparam int COUNT_W = 16;  // Longword counter

    // Byte moved over the peripheral port and through each lane
    typedef logic [BYTE_W-1:0] byteT;

    // Memory address, memory data and CPU register data
    typedef logic [WORD_W-1:0] wordT;

    // Remaining longword count
    typedef logic [COUNT_W-1:0] countT;

endpackage

/* verilog/fifoByteLane.sv */
/*
 * FIFO byte lane
 * Byte-wide circular buffer with its own pointers, fill count and flags
 */

`timescale 1ns/1ps

module fifoByteLane #(
    parameter int FIFO_DEPTH = 4   // Power of two
) (
    input  logic             QnCPUCLK,
    input  logic             arstN_i,
    input  logic             wr_i,
    input  dmacBusPkg::byteT wrData_i,
    input  logic             rd_i,
    output dmacBusPkg::byteT rdData_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    dmacBusPkg::byteT mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fillCnt;
    logic             wrEn;
    logic             rdEn;

    assign wrEn = wr_i && !full_o;    // Drop writes when full
    assign rdEn = rd_i && !empty_o;   // Drop reads when empty

    always_ff @(posedge QnCPUCLK) begin
        if (wrEn) mem[wrPtr] <= wrData_i;
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            fillCnt <= '0;
        end else begin
            if (wrEn) wrPtr <= wrPtr + 1'b1;
            if (rdEn) rdPtr <= rdPtr + 1'b1;
            case ({wrEn, rdEn})
                2'b10:   fillCnt <= fillCnt + 1'b1;
                2'b01:   fillCnt <= fillCnt - 1'b1;
                default: fillCnt <= fillCnt;
            endcase
        end
    end

    assign rdData_o = mem[rdPtr];   // Head entry
    assign full_o   = (fillCnt == CNT_W'(FIFO_DEPTH));
    assign empty_o  = (fillCnt == '0);

endmodule

/* verilog/scsiPortFeeder.sv */
/*
 * SCSI peripheral DMA feeder
 * Answers the chip's DMA request with dack/ior strobes and steers
 * each byte to the byte lane picked by a rolling byte pointer
 */

`timescale 1ns/1ps

module scsiPortFeeder (
    input  logic                         QnCPUCLK,
    input  logic                         arstN_i,
    input  logic                         dmaEna_i,
    input  logic                         dreq_i,
    input  dmacBusPkg::byteT             pd_i,
    input  logic [dmacBusPkg::LANES-1:0] laneFull_i,
    output logic                         dack_o,
    output logic                         ior_o,
    output logic [dmacBusPkg::LANES-1:0] laneWr_o,
    output dmacBusPkg::byteT             laneWrData_o
);

    localparam int PTR_W = $clog2(dmacBusPkg::LANES);

    typedef enum logic {
        FEED_IDLE,
        FEED_STROBE
    } feedStateT;

    feedStateT        state;
    logic [PTR_W-1:0] bytePtr;   // Byte k of a longword goes to lane k
    logic             strobe;
    logic             canFeed;

    assign strobe = (state == FEED_STROBE);

    // Only the lane the pointer selects matters
    assign canFeed = dmaEna_i && dreq_i && !laneFull_i[bytePtr];

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state   <= FEED_IDLE;
            bytePtr <= '0;
        end else begin
            case (state)
                FEED_IDLE: begin
                    if (canFeed) state <= FEED_STROBE;   // Stall here while lane is full
                end
                FEED_STROBE: begin
                    // Byte lands in the lane on this edge, always idle one cycle after
                    state   <= FEED_IDLE;
                    bytePtr <= bytePtr + 1'b1;
                end
                default: state <= FEED_IDLE;
            endcase
        end
    end

    // Write strobe to the selected lane for the whole ior cycle
    always_comb begin
        laneWr_o          = '0;
        laneWr_o[bytePtr] = strobe;
    end

    assign dack_o       = strobe;
    assign ior_o        = strobe;   // Read strobe never without dack
    assign laneWrData_o = pd_i;     // Sampled by the lane at the end of the strobe

endmodule

/* verilog/cpuBusMaster.sv */
/*
 * CPU side bus master
 * Requests the bus once a full longword sits in the lanes, then writes it
 * to memory with a request/acknowledge handshake and pops all lanes
 */

`timescale 1ns/1ps

module cpuBusMaster (
    input  logic                                            QnCPUCLK,
    input  logic                                            arstN_i,
    input  logic                                            xferActive_i,
    input  dmacBusPkg::wordT                                curAddr_i,
    input  logic [dmacBusPkg::LANES-1:0]                    laneEmpty_i,
    input  dmacBusPkg::byteT [dmacBusPkg::LANES-1:0]        laneRdData_i,
    input  logic                                            busGrant_i,
    input  logic                                            memAck_i,
    output logic                                            busReq_o,
    output logic                                            memWrReq_o,
    output dmacBusPkg::wordT                                memAddr_o,
    output dmacBusPkg::wordT                                memData_o,
    output logic                                            laneRd_o,
    output logic                                            wordDone_o
);

    typedef enum logic [1:0] {
        BM_IDLE,
        BM_REQ,
        BM_WRITE
    } busStateT;

    busStateT         state;
    dmacBusPkg::wordT packedWord;
    logic             wordReady;
    logic             ackSeen;

    // Lanes fill in order, so no lane empty means lane 3 holds a byte too
    assign wordReady = ~|laneEmpty_i;
    assign ackSeen   = (state == BM_WRITE) && memAck_i;

    // 68k big-endian order, lane 0 is the first byte and lands in 31:24
    always_comb begin
        packedWord = '0;
        for (int i = 0; i < dmacBusPkg::LANES; i++) begin
            packedWord[dmacBusPkg::WORD_W-1-i*dmacBusPkg::BYTE_W -: dmacBusPkg::BYTE_W] =
                laneRdData_i[i];
        end
    end

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= BM_IDLE;
        end else begin
            case (state)
                BM_IDLE: begin
                    if (xferActive_i && wordReady) state <= BM_REQ;
                end
                BM_REQ: begin
                    if (busGrant_i) state <= BM_WRITE;
                end
                BM_WRITE: begin
                    if (memAck_i) state <= BM_IDLE;   // Drop request and bus next edge
                end
                default: state <= BM_IDLE;
            endcase
        end
    end

    // Address and data held for the whole write cycle
    always_ff @(posedge QnCPUCLK) begin
        if (state == BM_REQ && busGrant_i) begin
            memAddr_o <= curAddr_i;
            memData_o <= packedWord;
        end
    end

    assign busReq_o   = (state != BM_IDLE);
    assign memWrReq_o = (state == BM_WRITE);
    assign laneRd_o   = ackSeen;   // Pop all four lanes together
    assign wordDone_o = ackSeen;

endmodule

/* verilog/dmacRegisters.sv */
/*
 * SDMAC CPU register block
 * Control, address and count registers with a status readback,
 * live address and count stepping per longword, done flag and interrupt
 */

`timescale 1ns/1ps

module dmacRegisters (
    input  logic                              QnCPUCLK,
    input  logic                              arstN_i,
    input  logic                              regWr_i,
    input  logic                              regRd_i,
    input  logic [dmacRegPkg::REG_ADDR_W-1:0] regAddr_i,
    input  dmacBusPkg::wordT                  regWrData_i,
    input  logic                              wordDone_i,
    input  logic                              fifoEmpty_i,
    input  logic                              fifoFull_i,
    output dmacBusPkg::wordT                  regRdData_o,
    output logic                              regRdValid_o,
    output logic                              dmaEna_o,
    output logic                              xferActive_o,
    output dmacBusPkg::wordT                  curAddr_o,
    output logic                              irq_o
);

    // One longword moves LANES bytes
    localparam dmacBusPkg::wordT ADDR_STEP = dmacBusPkg::wordT'(dmacBusPkg::LANES);

    dmacBusPkg::wordT  controlReg;
    dmacBusPkg::wordT  addrReg;
    dmacBusPkg::countT countReg;
    dmacBusPkg::wordT  statusWord;
    logic              done;
    logic              lastWord;   // Count just stepped from 1 to 0
    logic              wrControl;
    logic              wrAddress;
    logic              wrCount;
    logic              clrDone;

    assign wrControl = regWr_i && (regAddr_i == dmacRegPkg::REG_CONTROL);
    assign wrAddress = regWr_i && (regAddr_i == dmacRegPkg::REG_ADDRESS);
    assign wrCount   = regWr_i && (regAddr_i == dmacRegPkg::REG_COUNT);
    assign clrDone   = regWr_i && (regAddr_i == dmacRegPkg::REG_STATUS)
                       && regWrData_i[dmacRegPkg::STAT_DONE];

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            controlReg <= '0;
            addrReg    <= '0;
            countReg   <= '0;
            lastWord   <= 1'b0;
            done       <= 1'b0;
        end else begin
            if (wrControl) controlReg <= regWrData_i;

            // A CPU write wins over the per-word step
            if (wrAddress) begin
                addrReg <= regWrData_i;
            end else if (wordDone_i) begin
                addrReg <= addrReg + ADDR_STEP;
            end

            if (wrCount) begin
                countReg <= regWrData_i[dmacBusPkg::COUNT_W-1:0];
            end else if (wordDone_i) begin
                countReg <= countReg - 1'b1;
            end

            lastWord <= wordDone_i && !wrCount && (countReg == dmacBusPkg::countT'(1));

            if (lastWord) begin
                done <= 1'b1;                  // Count reached zero last edge
            end else if (clrDone) begin
                done <= 1'b0;
            end
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[dmacRegPkg::STAT_DONE]       = done;
        statusWord[dmacRegPkg::STAT_FIFO_EMPTY] = fifoEmpty_i;
        statusWord[dmacRegPkg::STAT_FIFO_FULL]  = fifoFull_i;
    end

    // Read data answers one cycle after the strobe
    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            regRdData_o  <= '0;
            regRdValid_o <= 1'b0;
        end else begin
            regRdValid_o <= regRd_i;
            if (regRd_i) begin
                case (regAddr_i)
                    dmacRegPkg::REG_CONTROL: regRdData_o <= controlReg;
                    dmacRegPkg::REG_ADDRESS: regRdData_o <= addrReg;
                    dmacRegPkg::REG_COUNT: begin
                        regRdData_o <= {{(dmacBusPkg::WORD_W-dmacBusPkg::COUNT_W){1'b0}},
                                        countReg};
                    end
                    default:                 regRdData_o <= statusWord;
                endcase
            end
        end
    end

    assign dmaEna_o     = controlReg[dmacRegPkg::CTRL_DMA_ENA];
    assign xferActive_o = dmaEna_o && (countReg != '0);
    assign curAddr_o    = addrReg;
    assign irq_o        = done && controlReg[dmacRegPkg::CTRL_INT_ENA];

endmodule

/* verilog/sdmacTop.sv */
/*
 * SCSI DMA controller top level
 * Joins the register block, peripheral feeder, byte lanes and bus master
 */

`timescale 1ns/1ps

module sdmacTop #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                              QnCPUCLK,
    input  logic                              arstN_i,
    // CPU register port
    input  logic                              regWr_i,
    input  logic                              regRd_i,
    input  logic [dmacRegPkg::REG_ADDR_W-1:0] regAddr_i,
    input  dmacBusPkg::wordT                  regWrData_i,
    output dmacBusPkg::wordT                  regRdData_o,
    output logic                              regRdValid_o,
    // Peripheral port
    input  logic                              dreq_i,
    input  dmacBusPkg::byteT                  pd_i,
    output logic                              dack_o,
    output logic                              ior_o,
    // Memory port
    output logic                              busReq_o,
    input  logic                              busGrant_i,
    output logic                              memWrReq_o,
    output dmacBusPkg::wordT                  memAddr_o,
    output dmacBusPkg::wordT                  memData_o,
    input  logic                              memAck_i,
    output logic                              irq_o
);

    logic [dmacBusPkg::LANES-1:0]             laneWr;
    logic [dmacBusPkg::LANES-1:0]             laneFull;
    logic [dmacBusPkg::LANES-1:0]             laneEmpty;
    dmacBusPkg::byteT [dmacBusPkg::LANES-1:0] laneRdData;
    dmacBusPkg::byteT                         laneWrData;
    dmacBusPkg::wordT                         curAddr;
    logic                                     laneRd;
    logic                                     dmaEna;
    logic                                     xferActive;
    logic                                     wordDone;

    dmacRegisters dmacRegisters_inst (
        .QnCPUCLK     (QnCPUCLK),
        .arstN_i      (arstN_i),
        .regWr_i      (regWr_i),
        .regRd_i      (regRd_i),
        .regAddr_i    (regAddr_i),
        .regWrData_i  (regWrData_i),
        .wordDone_i   (wordDone),
        .fifoEmpty_i  (laneEmpty[0]),                     // First lane to fill
        .fifoFull_i   (laneFull[dmacBusPkg::LANES-1]),    // Last lane to fill
        .regRdData_o  (regRdData_o),
        .regRdValid_o (regRdValid_o),
        .dmaEna_o     (dmaEna),
        .xferActive_o (xferActive),
        .curAddr_o    (curAddr),
        .irq_o        (irq_o)
    );

    scsiPortFeeder scsiPortFeeder_inst (
        .QnCPUCLK     (QnCPUCLK),
        .arstN_i      (arstN_i),
        .dmaEna_i     (dmaEna),
        .dreq_i       (dreq_i),
        .pd_i         (pd_i),
        .laneFull_i   (laneFull),
        .dack_o       (dack_o),
        .ior_o        (ior_o),
        .laneWr_o     (laneWr),
        .laneWrData_o (laneWrData)
    );

    // One byte lane per longword byte
    for (genvar i = 0; i < dmacBusPkg::LANES; i++) begin : gLane
        fifoByteLane #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) fifoByteLane_inst (
            .QnCPUCLK (QnCPUCLK),
            .arstN_i  (arstN_i),
            .wr_i     (laneWr[i]),
            .wrData_i (laneWrData),
            .rd_i     (laneRd),
            .rdData_o (laneRdData[i]),
            .full_o   (laneFull[i]),
            .empty_o  (laneEmpty[i])
        );
    end

    cpuBusMaster cpuBusMaster_inst (
        .QnCPUCLK     (QnCPUCLK),
        .arstN_i      (arstN_i),
        .xferActive_i (xferActive),
        .curAddr_i    (curAddr),
        .laneEmpty_i  (laneEmpty),
        .laneRdData_i (laneRdData),
        .busGrant_i   (busGrant_i),
        .memAck_i     (memAck_i),
        .busReq_o     (busReq_o),
        .memWrReq_o   (memWrReq_o),
        .memAddr_o    (memAddr_o),
        .memData_o    (memData_o),
        .laneRd_o     (laneRd),
        .wordDone_o   (wordDone)
    );

endmodule

/* tests/sdmacTb_assert.sv */
/*
 * SDMAC protocol assertions
 * Bound to the top level, watches the peripheral strobes and the memory write handshake
 */

`timescale 1ns/1ps

module sdmacAssert (
    input logic             QnCPUCLK,
    input logic             arstN_i,
    input logic             dack_i,
    input logic             ior_i,
    input logic             busGrant_i,
    input logic             memWrReq_i,
    input logic             memAck_i,
    input dmacBusPkg::wordT memAddr_i,
    input dmacBusPkg::wordT memData_i
);

    iorWithDack: assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        ior_i |-> dack_i) else $error("ior strobe without dack");

    // At least one idle cycle between two strobes
    iorSingleCycle: assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        ior_i |=> !ior_i) else $error("ior high for two cycles in a row");

    writeNeedsGrant: assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        memWrReq_i |-> busGrant_i) else $error("memory write request without bus grant");

    // Request, address and data hold until the acknowledge
    writeHeld: assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        (memWrReq_i && !memAck_i) |=> memWrReq_i && $stable(memAddr_i) && $stable(memData_i))
        else $error("memory write changed before acknowledge");

endmodule

bind sdmacTop sdmacAssert sdmacAssert_inst (
    .QnCPUCLK   (QnCPUCLK),
    .arstN_i    (arstN_i),
    .dack_i     (dack_o),
    .ior_i      (ior_o),
    .busGrant_i (busGrant_i),
    .memWrReq_i (memWrReq_o),
    .memAck_i   (memAck_i),
    .memAddr_i  (memAddr_o),
    .memData_i  (memData_o)
);

/* tests/sdmacTb.sv */
/*
 * SDMAC testbench
 * Peripheral and memory models around the DMA controller, checks register
 * readback, every memory write and the completion state
 */

`timescale 1ns/1ps

module sdmacTb;

    localparam int FIFO_DEPTH  = 4;
    localparam int N_BASIC     = 6;
    localparam int N_STALL     = 8;
    localparam int N_FULL      = FIFO_DEPTH + 2;   // More than the FIFO holds
    localparam int FULL_BYTES  = FIFO_DEPTH * dmacBusPkg::LANES;
    localparam int TOTAL_BYTES = dmacBusPkg::LANES * (N_BASIC + N_STALL + N_FULL);
    localparam int CYCLE_LIMIT = 20 * TOTAL_BYTES + 2000;

    logic                              QnCPUCLK;
    logic                              arstN_i;
    logic                              regWr_i;
    logic                              regRd_i;
    logic [dmacRegPkg::REG_ADDR_W-1:0] regAddr_i;
    dmacBusPkg::wordT                  regWrData_i;
    dmacBusPkg::wordT                  regRdData_o;
    logic                              regRdValid_o;
    logic                              dreq_i;
    dmacBusPkg::byteT                  pd_i;
    logic                              dack_o;
    logic                              ior_o;
    logic                              busReq_o;
    logic                              busGrant_i;
    logic                              memWrReq_o;
    dmacBusPkg::wordT                  memAddr_o;
    dmacBusPkg::wordT                  memData_o;
    logic                              memAck_i;
    logic                              irq_o;

    dmacBusPkg::byteT byteQ[$];      // Every byte the peripheral sends, in order
    dmacBusPkg::wordT addrLog[$];
    dmacBusPkg::wordT dataLog[$];
    event             wordLogged;
    dmacBusPkg::wordT testStart;
    dmacBusPkg::wordT wrVal;
    dmacBusPkg::wordT rdVal;
    int               byteIdx;       // Bytes taken by ior strobes
    int               wordIdx;       // Memory writes compared so far
    int               wordsTotal;
    int               testByteBase;
    int               testWordBase;
    int               wordOff;
    int               grantMax;
    int               ackMax;
    int               grantWait;
    int               ackWait;
    int               cycleCnt;
    bit               iorSeen;
    bit               dreqGaps;
    bit               grantHold;

    sdmacTop #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdmacTop_inst (.*);

    always #2 QnCPUCLK = ~QnCPUCLK;  // 4 ns period

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input dmacBusPkg::wordT expVal,
                             input dmacBusPkg::wordT actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
            stopRun();
        end
    endtask

    task automatic checkCount(input string name, input dmacBusPkg::countT expVal,
                              input dmacBusPkg::countT actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expVal, actVal);
            stopRun();
        end
    endtask

    // Bytes 4k to 4k+3 of the current test with the first byte on top
    function automatic dmacBusPkg::wordT expectedWord(input int wordNum);
        int b;
        b = testByteBase + dmacBusPkg::LANES * wordNum;
        return {byteQ[b], byteQ[b+1], byteQ[b+2], byteQ[b+3]};
    endfunction

    task automatic writeReg(input logic [dmacRegPkg::REG_ADDR_W-1:0] addr,
                            input dmacBusPkg::wordT data);
        @(posedge QnCPUCLK);
        #1;
        regWr_i     = 1'b1;
        regAddr_i   = addr;
        regWrData_i = data;
        @(posedge QnCPUCLK);
        #1;
        regWr_i = 1'b0;
    endtask

    task automatic readReg(input logic [dmacRegPkg::REG_ADDR_W-1:0] addr,
                           output dmacBusPkg::wordT data);
        @(posedge QnCPUCLK);
        #1;
        regRd_i   = 1'b1;
        regAddr_i = addr;
        @(posedge QnCPUCLK);
        #1;
        regRd_i = 1'b0;
        data    = regRdData_o;
        if (!regRdValid_o) begin
            $display("Read of register %0d got no answer one cycle later", addr);
            stopRun();
        end
    endtask

    task automatic startTransfer(input int words, input bit intEna);
        dmacBusPkg::wordT ctrl;
        testStart    = dmacBusPkg::wordT'($urandom) & 32'h00FF_FFFC;  // Longword aligned
        testByteBase = byteQ.size();
        testWordBase = wordsTotal;
        wordsTotal   = wordsTotal + words;
        ctrl = '0;
        ctrl[dmacRegPkg::CTRL_DMA_ENA] = 1'b1;
        ctrl[dmacRegPkg::CTRL_INT_ENA] = intEna;
        writeReg(dmacRegPkg::REG_ADDRESS, testStart);
        writeReg(dmacRegPkg::REG_COUNT, dmacBusPkg::wordT'(words));
        writeReg(dmacRegPkg::REG_CONTROL, ctrl);
        for (int i = 0; i < dmacBusPkg::LANES * words; i++) begin
            byteQ.push_back(dmacBusPkg::byteT'($urandom));
        end
    endtask

    task automatic finishTransfer(input int words, input bit intEna);
        dmacBusPkg::wordT stat;
        dmacBusPkg::wordT val;
        while (wordIdx < wordsTotal) @(posedge QnCPUCLK);
        stat = '0;
        while (!stat[dmacRegPkg::STAT_DONE]) readReg(dmacRegPkg::REG_STATUS, stat);
        checkWord("STATUS", (1 << dmacRegPkg::STAT_DONE) | (1 << dmacRegPkg::STAT_FIFO_EMPTY),
                  stat);
        readReg(dmacRegPkg::REG_ADDRESS, val);
        checkWord("ADDRESS", testStart + dmacBusPkg::wordT'(4 * words), val);
        readReg(dmacRegPkg::REG_COUNT, val);
        checkCount("COUNT", '0, val[dmacBusPkg::COUNT_W-1:0]);
        checkWord("irq_o", dmacBusPkg::wordT'(intEna), dmacBusPkg::wordT'(irq_o));
        writeReg(dmacRegPkg::REG_STATUS, 1 << dmacRegPkg::STAT_DONE);   // Write 1 to clear
        readReg(dmacRegPkg::REG_STATUS, val);
        checkWord("STATUS", 1 << dmacRegPkg::STAT_FIFO_EMPTY, val);
        checkWord("irq_o", '0, dmacBusPkg::wordT'(irq_o));
        writeReg(dmacRegPkg::REG_CONTROL, '0);
    endtask

    // Peripheral and memory models
    always begin
        @(posedge QnCPUCLK);
        #1;
        if (iorSeen) byteIdx++;          // Byte was taken on the edge that ended ior
        iorSeen = ior_o;
        pd_i    = (byteIdx < byteQ.size()) ? byteQ[byteIdx] : '0;
        dreq_i  = (byteIdx < byteQ.size()) && (!dreqGaps || $urandom_range(3, 0) != 0);
        if (!busReq_o) begin
            busGrant_i = 1'b0;
            grantWait  = $urandom_range(grantMax, 0);
        end else if (!busGrant_i && !grantHold) begin
            if (grantWait == 0) busGrant_i = 1'b1;
            else grantWait--;
        end
        if (memAck_i) begin
            memAck_i = 1'b0;
        end else if (memWrReq_o) begin
            if (ackWait == 0) begin
                memAck_i = 1'b1;         // Write accepted in this cycle
                addrLog.push_back(memAddr_o);
                dataLog.push_back(memData_o);
                ackWait = $urandom_range(ackMax, 0);
                -> wordLogged;
            end else begin
                ackWait--;
            end
        end
    end

    // Compares each accepted memory write with the reference
    always begin
        @(wordLogged);
        while (addrLog.size() > 0) begin
            wordOff = wordIdx - testWordBase;
            if (wordIdx >= wordsTotal) begin
                $display("Memory write at %0t with no longword left to transfer", $time);
                stopRun();
            end else begin
                checkWord("memAddr_o", testStart + dmacBusPkg::wordT'(4 * wordOff),
                          addrLog.pop_front());
                checkWord("memData_o", expectedWord(wordOff), dataLog.pop_front());
                wordIdx++;
            end
        end
    end

    initial begin
        cycleCnt = 0;
        while (cycleCnt < CYCLE_LIMIT) begin
            @(posedge QnCPUCLK);
            cycleCnt++;
        end
        $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        stopRun();
    end

    initial begin
        void'($urandom(77));
        QnCPUCLK    = 1'b0;
        arstN_i     = 1'b0;
        regWr_i     = 1'b0;
        regRd_i     = 1'b0;
        regAddr_i   = '0;
        regWrData_i = '0;
        dreq_i      = 1'b0;
        pd_i        = '0;
        busGrant_i  = 1'b0;
        memAck_i    = 1'b0;
        repeat (10) @(posedge QnCPUCLK);
        #1;
        arstN_i = 1'b1;

        // Reset state
        checkWord("irq_o", '0, dmacBusPkg::wordT'(irq_o));
        checkWord("busReq_o", '0, dmacBusPkg::wordT'(busReq_o));
        checkWord("memWrReq_o", '0, dmacBusPkg::wordT'(memWrReq_o));
        checkWord("dack_o", '0, dmacBusPkg::wordT'(dack_o));
        checkWord("ior_o", '0, dmacBusPkg::wordT'(ior_o));
        readReg(dmacRegPkg::REG_CONTROL, rdVal);
        checkWord("CONTROL", '0, rdVal);
        readReg(dmacRegPkg::REG_ADDRESS, rdVal);
        checkWord("ADDRESS", '0, rdVal);
        readReg(dmacRegPkg::REG_COUNT, rdVal);
        checkCount("COUNT", '0, rdVal[dmacBusPkg::COUNT_W-1:0]);
        readReg(dmacRegPkg::REG_STATUS, rdVal);
        checkWord("STATUS", 1 << dmacRegPkg::STAT_FIFO_EMPTY, rdVal);

        // Register readback with random values
        for (int i = 0; i < 3; i++) begin
            wrVal = dmacBusPkg::wordT'($urandom);
            writeReg(dmacRegPkg::REG_ADDRESS, wrVal);
            readReg(dmacRegPkg::REG_ADDRESS, rdVal);
            checkWord("ADDRESS", wrVal, rdVal);
            writeReg(dmacRegPkg::REG_COUNT, ~wrVal);
            readReg(dmacRegPkg::REG_COUNT, rdVal);
            checkCount("COUNT", ~wrVal[dmacBusPkg::COUNT_W-1:0], rdVal[dmacBusPkg::COUNT_W-1:0]);
            wrVal = dmacBusPkg::wordT'($urandom);
            writeReg(dmacRegPkg::REG_CONTROL, wrVal);
            readReg(dmacRegPkg::REG_CONTROL, rdVal);
            checkWord("CONTROL", wrVal, rdVal);
        end
        writeReg(dmacRegPkg::REG_CONTROL, '0);
        writeReg(dmacRegPkg::REG_COUNT, '0);

        // Memory always ready, no interrupt
        startTransfer(N_BASIC, 1'b0);
        finishTransfer(N_BASIC, 1'b0);

        // Random dreq gaps, grant and acknowledge delays, interrupt on
        dreqGaps = 1'b1;
        grantMax = 7;
        ackMax   = 7;
        startTransfer(N_STALL, 1'b1);
        finishTransfer(N_STALL, 1'b1);

        // FIFO fills up while the bus stays ungranted
        dreqGaps  = 1'b0;
        grantHold = 1'b1;
        startTransfer(N_FULL, 1'b0);
        while (byteIdx - testByteBase < FULL_BYTES) @(posedge QnCPUCLK);
        repeat (20) @(posedge QnCPUCLK);        // Long enough for a stray strobe to show
        checkCount("ior_o strobes", dmacBusPkg::countT'(FULL_BYTES),
                   dmacBusPkg::countT'(byteIdx - testByteBase));
        readReg(dmacRegPkg::REG_STATUS, rdVal);
        checkWord("STATUS", 1 << dmacRegPkg::STAT_FIFO_FULL, rdVal);
        grantHold = 1'b0;
        finishTransfer(N_FULL, 1'b0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* filelist.f */
verilog/dmacRegPkg.sv
verilog/dmacBusPkg.sv
verilog/fifoByteLane.sv
verilog/scsiPortFeeder.sv
verilog/cpuBusMaster.sv
verilog/dmacRegisters.sv
verilog/sdmacTop.sv
tests/sdmacTb_assert.sv
tests/sdmacTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sdmacTb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
